// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_depar
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== act_table_if.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

interface act_table_if;
	import depar_pkg::*;

	logic                         wr_en;
	logic                         wr_hi;   // upper half of the entry
	logic [ENTRY_W-1:0]           entry;
	logic [`DEPAR_APB_DATA_W-1:0] wr_word;
	logic [`DEPAR_APB_DATA_W-1:0] rd_word;

	modport cfg (
		output wr_en, wr_hi, entry, wr_word,
		input  rd_word
	);

	modport tbl (
		input  wr_en, wr_hi, entry, wr_word,
		output rd_word
	);

endinterface

// ==== compile.f ====
+incdir+.
depar_pkg.sv
act_table_if.sv
field_if.sv
depar_cfg_apb.sv
depar_act_table.sv
depar_field_extract.sv
depar_ctrl.sv
depar_top.sv
tb_depar.sv

// ==== depar_act_table.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module depar_act_table (
	input  logic                          clk,
	input  logic                          aresetn,
	input  logic [depar_pkg::ENTRY_W-1:0] lookup_addr,
	output depar_pkg::act_entry_t         lookup_entry,
	act_table_if.tbl                      tbl_if
);
	import depar_pkg::*;

	localparam int HALF_W = `DEPAR_APB_DATA_W;

	logic [2*HALF_W-1:0] mem [`DEPAR_TBL_DEPTH];

	// all actions disabled out of reset
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < `DEPAR_TBL_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (tbl_if.wr_en) begin
			if (tbl_if.wr_hi) begin
				mem[tbl_if.entry][HALF_W +: HALF_W] <= tbl_if.wr_word;
			end else begin
				mem[tbl_if.entry][0 +: HALF_W] <= tbl_if.wr_word;
			end
		end
	end

	// readback for apb
	assign tbl_if.rd_word = tbl_if.wr_hi ? mem[tbl_if.entry][HALF_W +: HALF_W]
		: mem[tbl_if.entry][0 +: HALF_W];

	always_ff @(posedge clk) begin
		lookup_entry <= act_entry_t'(mem[lookup_addr]);  // one cycle lookup
	end

endmodule

// ==== depar_cfg_apb.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module depar_cfg_apb (
	input  logic                         clk,
	input  logic                         aresetn,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [`DEPAR_APB_ADDR_W-1:0] paddr,
	input  logic [`DEPAR_APB_DATA_W-1:0] pwdata,
	output logic [`DEPAR_APB_DATA_W-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr,
	act_table_if.cfg                     tbl_if
);
	import depar_pkg::*;

	logic aligned;
	logic access;

	assign aligned = (paddr[1:0] == 2'b00);
	assign access = psel && penable;

	assign tbl_if.entry = paddr[`DEPAR_APB_ENTRY_LSB +: ENTRY_W];
	assign tbl_if.wr_hi = paddr[`DEPAR_APB_HI_BIT];
	assign tbl_if.wr_word = pwdata;
	// the table takes the word at the end of the access cycle
	assign tbl_if.wr_en = access && pwrite && aligned;

	assign pready = 1'b1;  // no wait states
	assign pslverr = access && !aligned;

	always_comb begin
		prdata = '0;
		if (psel && !pwrite && aligned) begin
			prdata = tbl_if.rd_word;
		end
	end

	a_penable_sel: assert property (
		@(posedge clk) disable iff (!aresetn)
		penable |-> psel
	) else $error("apb penable high without psel");

endmodule

// ==== depar_ctrl.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module depar_ctrl (
	input  logic                          clk,
	input  logic                          aresetn,
	input  logic [`DEPAR_DATA_W-1:0]      pkt_tdata,
	input  logic [`DEPAR_KEEP_W-1:0]      pkt_tkeep,
	input  logic [`DEPAR_USER_W-1:0]      pkt_tuser,
	input  logic                          pkt_tlast,
	input  logic                          pkt_empty,
	output logic                          pkt_rd_en,
	input  logic                          phv_empty,
	output logic                          phv_rd_en,
	input  logic                          phv_discard,
	input  logic [`DEPAR_USER_W-1:0]      phv_user,
	input  logic [depar_pkg::VLAN_W-1:0]  phv_vlan,
	output logic [depar_pkg::ENTRY_W-1:0] lookup_addr,
	input  depar_pkg::act_entry_t         lookup_entry,
	field_if.ctrl                         fld,
	output logic [`DEPAR_DATA_W-1:0]      out_tdata,
	output logic [`DEPAR_KEEP_W-1:0]      out_tkeep,
	output logic [`DEPAR_USER_W-1:0]      out_tuser,
	output logic                          out_tlast,
	output logic                          out_tvalid,
	input  logic                          out_tready
);
	import depar_pkg::*;

	localparam int BUF_BYTES = `DEPAR_BUF_BEATS * `DEPAR_KEEP_W;
	localparam int DW = `DEPAR_DATA_W;
	localparam int KW = `DEPAR_KEEP_W;

	depar_state_e state, state_next;

	logic [`DEPAR_BUF_BEATS*DW-1:0] buf_data;
	logic [`DEPAR_BUF_BEATS*DW-1:0] patched;
	logic [`DEPAR_BUF_BEATS*KW-1:0] buf_keep;
	logic [`DEPAR_USER_W-1:0]       buf_user [`DEPAR_BUF_BEATS];
	logic [`DEPAR_BUF_BEATS-1:0]    buf_last;
	logic                           both_ready;

	assign both_ready = !pkt_empty && !phv_empty;
	assign lookup_addr = phv_vlan[VLAN_TBL_LSB +: ENTRY_W];

	// entry has been registered since the IDLE cycle
	assign fld.start = (state == EXTRACT);
	assign fld.act = lookup_entry;

	always_comb begin
		state_next = state;
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		case (state)
			IDLE: begin
				if (both_ready) begin
					pkt_rd_en = 1'b1;
					if (phv_discard) begin
						phv_rd_en = 1'b1;
						state_next = pkt_tlast ? IDLE : DROP;  // single beat drop is done
					end else begin
						state_next = pkt_tlast ? EXTRACT : BEAT1;
					end
				end
			end
			BEAT1: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					state_next = EXTRACT;
				end
			end
			EXTRACT: state_next = PATCH;
			PATCH: state_next = OUT0;
			OUT0: begin
				if (out_tready) begin
					phv_rd_en = 1'b1;
					state_next = buf_last[0] ? IDLE : OUT1;
				end
			end
			OUT1: begin
				if (out_tready) begin
					state_next = buf_last[1] ? IDLE : STREAM;
				end
			end
			STREAM: begin
				if (!pkt_empty && out_tready) begin
					pkt_rd_en = 1'b1;
					if (pkt_tlast) begin
						state_next = IDLE;
					end
				end
			end
			DROP: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					if (pkt_tlast) begin
						state_next = IDLE;
					end
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// all four actions in one pass, later ones overwrite earlier ones
	always_comb begin
		logic [2:0] nbytes;
		logic [7:0] off_end;
		patched = buf_data;
		for (int i = 0; i < `DEPAR_NUM_ACT; i++) begin
			nbytes = {fld.size[i], 1'b0};
			off_end = {1'b0, lookup_entry[i].offset} + {5'd0, nbytes};
			if (nbytes != 3'd0 && off_end <= BUF_BYTES) begin
				for (int k = 0; k < 6; k++) begin
					if (k < nbytes) begin
						patched[(lookup_entry[i].offset + k)*8 +: 8] = fld.val[i][k*8 +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (both_ready) begin
					buf_data[0 +: DW] <= pkt_tdata;
					buf_keep[0 +: KW] <= pkt_tkeep;
					buf_user[0] <= phv_user;  // metadata replaces beat 0 tuser
					buf_last[0] <= pkt_tlast;
				end
			end
			BEAT1: begin
				if (!pkt_empty) begin
					buf_data[DW +: DW] <= pkt_tdata;
					buf_keep[KW +: KW] <= pkt_tkeep;
					buf_user[1] <= pkt_tuser;
					buf_last[1] <= pkt_tlast;
				end
			end
			PATCH: buf_data <= patched;
			default: ;
		endcase
	end

	always_comb begin
		out_tdata = pkt_tdata;
		out_tkeep = pkt_tkeep;
		out_tuser = pkt_tuser;
		out_tlast = pkt_tlast;
		out_tvalid = 1'b0;
		case (state)
			OUT0: begin
				out_tdata = buf_data[0 +: DW];
				out_tkeep = buf_keep[0 +: KW];
				out_tuser = buf_user[0];
				out_tlast = buf_last[0];
				out_tvalid = 1'b1;
			end
			OUT1: begin
				out_tdata = buf_data[DW +: DW];
				out_tkeep = buf_keep[KW +: KW];
				out_tuser = buf_user[1];
				out_tlast = buf_last[1];
				out_tvalid = 1'b1;
			end
			STREAM: out_tvalid = !pkt_empty;  // fifo head passes straight through
			default: ;
		endcase
	end

	a_out_stable: assert property (
		@(posedge clk) disable iff (!aresetn)
		out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
	) else $error("output beat changed while stalled");

endmodule

// ==== depar_field_extract.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module depar_field_extract (
	input  logic                    clk,
	input  logic                    aresetn,
	input  logic [`DEPAR_PHV_W-1:0] phv,
	field_if.extract                fld
);
	import depar_pkg::*;

	localparam int VAL_BYTES = $bits(field_val_t) / 8;

	for (genvar i = 0; i < `DEPAR_NUM_ACT; i++) begin : g_lane
		depar_act_t act;
		logic [47:0] raw;
		logic [2:0]  nbytes;
		field_val_t  swapped;
		field_val_t  val_q;
		cont_size_e  size_q;

		assign act = fld.act[i];
		assign nbytes = {act.size, 1'b0};

		always_comb begin
			raw = '0;
			case (act.size)
				B2: raw[15:0] = phv[PHV_B2_BASE + act.index * 16 +: 16];
				B4: raw[31:0] = phv[PHV_B4_BASE + act.index * 32 +: 32];
				B6: raw = phv[PHV_B6_BASE + act.index * 48 +: 48];
				default: raw = '0;
			endcase
		end

		// msb of the container becomes byte 0
		always_comb begin
			swapped = '0;
			for (int k = 0; k < VAL_BYTES; k++) begin
				if (k < nbytes) begin
					swapped[k*8 +: 8] = raw[(nbytes - 1 - k)*8 +: 8];
				end
			end
		end

		always_ff @(posedge clk) begin
			if (fld.start) begin
				val_q <= swapped;
			end
		end

		always_ff @(posedge clk) begin
			if (!aresetn) begin
				size_q <= NONE;
			end else if (fld.start) begin
				size_q <= act.enable ? act.size : NONE;  // disabled lanes report NONE
			end
		end

		assign fld.val[i] = val_q;
		assign fld.size[i] = size_q;

		a_enabled_size: assert property (
			@(posedge clk) disable iff (!aresetn)
			fld.start && act.enable |-> act.size != NONE
		) else $error("lane %0d enabled with size NONE", i);
	end

endmodule

// ==== depar_pkg.sv ====
`include "depar_settings.svh"

package depar_pkg;

	typedef enum logic [7:0] {
		IDLE,
		BEAT1,
		EXTRACT,
		PATCH,
		OUT0,
		OUT1,
		STREAM,
		DROP
	} depar_state_e;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		B2   = 2'd1,
		B4   = 2'd2,
		B6   = 2'd3
	} cont_size_e;

	typedef struct packed {
		logic [2:0] spare;
		logic [6:0] offset;  // byte offset in the 64 byte buffer
		logic [2:0] index;
		cont_size_e size;
		logic       enable;
	} depar_act_t;

	// action 0 in the low 16 bits
	typedef depar_act_t [`DEPAR_NUM_ACT-1:0] act_entry_t;

	// byte 0 in [7:0] goes out first
	typedef logic [47:0] field_val_t;

	localparam int ENTRY_W = $clog2(`DEPAR_TBL_DEPTH);

	// metadata positions in the phv
	localparam int PHV_USER_LSB = 0;
	localparam int PHV_DISCARD_BIT = 128;
	localparam int PHV_VLAN_LSB = 129;
	localparam int VLAN_W = 12;
	localparam int VLAN_TBL_LSB = 4;

	// container groups
	localparam int PHV_B2_BASE = 256;
	localparam int PHV_B4_BASE = PHV_B2_BASE + 8 * 16;
	localparam int PHV_B6_BASE = PHV_B4_BASE + 8 * 32;

endpackage

// ==== depar_settings.svh ====
`ifndef DEPAR_SETTINGS_SVH
`define DEPAR_SETTINGS_SVH

// stream widths
`define DEPAR_DATA_W 256
`define DEPAR_KEEP_W 32
`define DEPAR_USER_W 128

// metadata [255:0], then 8 x 2B, 8 x 4B and 8 x 6B containers
`define DEPAR_PHV_W 1024

`define DEPAR_NUM_ACT 4
`define DEPAR_TBL_DEPTH 32
`define DEPAR_BUF_BEATS 2

// apb map: entry in [7:3], word select in [2]
`define DEPAR_APB_ADDR_W 8
`define DEPAR_APB_DATA_W 32
`define DEPAR_APB_ENTRY_LSB 3
`define DEPAR_APB_HI_BIT 2

`endif

// ==== depar_top.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module depar_top (
	input  logic                         clk,
	input  logic                         aresetn,
	input  logic [`DEPAR_DATA_W-1:0]     pkt_tdata,
	input  logic [`DEPAR_KEEP_W-1:0]     pkt_tkeep,
	input  logic [`DEPAR_USER_W-1:0]     pkt_tuser,
	input  logic                         pkt_tlast,
	input  logic                         pkt_empty,
	output logic                         pkt_rd_en,
	input  logic [`DEPAR_PHV_W-1:0]      phv_data,
	input  logic                         phv_empty,
	output logic                         phv_rd_en,
	output logic [`DEPAR_DATA_W-1:0]     out_tdata,
	output logic [`DEPAR_KEEP_W-1:0]     out_tkeep,
	output logic [`DEPAR_USER_W-1:0]     out_tuser,
	output logic                         out_tlast,
	output logic                         out_tvalid,
	input  logic                         out_tready,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [`DEPAR_APB_ADDR_W-1:0] paddr,
	input  logic [`DEPAR_APB_DATA_W-1:0] pwdata,
	output logic [`DEPAR_APB_DATA_W-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr
);
	import depar_pkg::*;

	logic [ENTRY_W-1:0] lookup_addr;
	act_entry_t         lookup_entry;

	act_table_if u_tbl_if ();
	field_if     u_fld_if ();

	depar_cfg_apb u_cfg_apb (
		.clk     (clk),
		.aresetn (aresetn),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.tbl_if  (u_tbl_if.cfg)
	);

	depar_act_table u_act_table (
		.clk          (clk),
		.aresetn      (aresetn),
		.lookup_addr  (lookup_addr),
		.lookup_entry (lookup_entry),
		.tbl_if       (u_tbl_if.tbl)
	);

	depar_field_extract u_field_extract (
		.clk     (clk),
		.aresetn (aresetn),
		.phv     (phv_data),
		.fld     (u_fld_if.extract)
	);

	depar_ctrl u_ctrl (
		.clk          (clk),
		.aresetn      (aresetn),
		.pkt_tdata    (pkt_tdata),
		.pkt_tkeep    (pkt_tkeep),
		.pkt_tuser    (pkt_tuser),
		.pkt_tlast    (pkt_tlast),
		.pkt_empty    (pkt_empty),
		.pkt_rd_en    (pkt_rd_en),
		.phv_empty    (phv_empty),
		.phv_rd_en    (phv_rd_en),
		.phv_discard  (phv_data[PHV_DISCARD_BIT]),
		.phv_user     (phv_data[PHV_USER_LSB +: `DEPAR_USER_W]),
		.phv_vlan     (phv_data[PHV_VLAN_LSB +: VLAN_W]),
		.lookup_addr  (lookup_addr),
		.lookup_entry (lookup_entry),
		.fld          (u_fld_if.ctrl),
		.out_tdata    (out_tdata),
		.out_tkeep    (out_tkeep),
		.out_tuser    (out_tuser),
		.out_tlast    (out_tlast),
		.out_tvalid   (out_tvalid),
		.out_tready   (out_tready)
	);

endmodule

// ==== field_if.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

interface field_if;
	import depar_pkg::*;

	logic       start;
	act_entry_t act;
	// valid one cycle after start, held until the next one
	field_val_t val [`DEPAR_NUM_ACT];
	cont_size_e size [`DEPAR_NUM_ACT];

	modport ctrl (
		output start, act,
		input  val, size
	);

	modport extract (
		input  start, act,
		output val, size
	);

endinterface

// ==== tb_depar.sv ====
`timescale 1ns/100ps
`include "depar_settings.svh"

module tb_depar;
	import depar_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int DW = `DEPAR_DATA_W;
	localparam int KW = `DEPAR_KEEP_W;
	localparam int UW = `DEPAR_USER_W;
	localparam int PW = `DEPAR_PHV_W;
	localparam int AW = `DEPAR_APB_ADDR_W;
	localparam int WW = `DEPAR_APB_DATA_W;

	typedef struct packed {
		logic [DW-1:0] data;
		logic [KW-1:0] keep;
		logic [UW-1:0] user;
		logic          last;
	} beat_t;

	logic          clk = 1'b0;
	logic          aresetn = 1'b0;
	logic [DW-1:0] pkt_tdata = '0;
	logic [KW-1:0] pkt_tkeep = '0;
	logic [UW-1:0] pkt_tuser = '0;
	logic          pkt_tlast = 1'b0;
	logic          pkt_empty = 1'b1;
	logic          pkt_rd_en;
	logic [PW-1:0] phv_data = '0;
	logic          phv_empty = 1'b1;
	logic          phv_rd_en;
	logic [DW-1:0] out_tdata;
	logic [KW-1:0] out_tkeep;
	logic [UW-1:0] out_tuser;
	logic          out_tlast;
	logic          out_tvalid;
	logic          out_tready = 1'b1;
	logic          psel = 1'b0;
	logic          penable = 1'b0;
	logic          pwrite = 1'b0;
	logic [AW-1:0] paddr = '0;
	logic [WW-1:0] pwdata = '0;
	logic [WW-1:0] prdata;
	logic          pready;
	logic          pslverr;

	beat_t         in_q [$];
	beat_t         exp_q [$];
	beat_t         got_q [$];
	logic [PW-1:0] phv_q [$];
	logic [63:0]   tbl_model [`DEPAR_TBL_DEPTH];
	logic [31:0]   lcg_state = 32'h6eae_fe59;
	logic          bp_mode = 1'b0;  // random out_tready and packet fifo gaps
	int            value_errors = 0;
	int            other_errors = 0;

	depar_top u_dut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [DW-1:0] rand_data();
		logic [DW-1:0] v;
		for (int i = 0; i < DW / 32; i++) begin
			v[i*32 +: 32] = lcg_next();
		end
		return v;
	endfunction

	// show-ahead fifo models and the output monitor sample mid-cycle
	always begin : fifo_model
		logic        pkt_pop;
		logic        phv_pop;
		logic [31:0] r;
		@(negedge clk);
		pkt_pop = pkt_rd_en;
		phv_pop = phv_rd_en;
		if (pkt_rd_en && pkt_empty) begin
			$display("packet FIFO was read while empty at %0t", $time);
			other_errors++;
		end
		if (phv_rd_en && phv_empty) begin
			$display("PHV FIFO was read while empty at %0t", $time);
			other_errors++;
		end
		if (out_tvalid && out_tready) begin
			got_q.push_back({out_tdata, out_tkeep, out_tuser, out_tlast});
		end
		@(posedge clk);
		#1;
		r = lcg_next();
		if (pkt_pop && in_q.size() > 0) begin
			void'(in_q.pop_front());
		end
		if (phv_pop && phv_q.size() > 0) begin
			void'(phv_q.pop_front());
		end
		// a shown head stays until it is popped
		if (pkt_pop || pkt_empty) begin
			pkt_empty = (in_q.size() == 0) || (bp_mode && r[5]);
		end
		phv_empty = (phv_q.size() == 0);
		pkt_tdata = pkt_empty ? '0 : in_q[0].data;
		pkt_tkeep = pkt_empty ? '0 : in_q[0].keep;
		pkt_tuser = pkt_empty ? '0 : in_q[0].user;
		pkt_tlast = pkt_empty ? 1'b0 : in_q[0].last;
		phv_data = phv_empty ? '0 : phv_q[0];
		out_tready = bp_mode ? r[17] : 1'b1;
	end

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_word(input string what, input logic [WW-1:0] got,
		input logic [WW-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_beat(input int idx, input beat_t got, input beat_t exp);
		if (got.data !== exp.data) begin
			$display("FAILED out_tdata beat %0d: got %h expected %h", idx, got.data, exp.data);
			value_errors++;
		end
		if (got.keep !== exp.keep) begin
			$display("FAILED out_tkeep beat %0d: got %h expected %h", idx, got.keep, exp.keep);
			value_errors++;
		end
		if (got.user !== exp.user) begin
			$display("FAILED out_tuser beat %0d: got %h expected %h", idx, got.user, exp.user);
			value_errors++;
		end
		check_flag("out_tlast", got.last, exp.last);
	endtask

	// one apb transfer starting and ending just after a rising edge
	task automatic apb_access(input logic write, input logic [AW-1:0] addr,
		input logic [WW-1:0] wdata, output logic [WW-1:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		check_flag("pready", pready, 1'b1);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_entry(input int e, input logic [63:0] word);
		logic [WW-1:0] rd;
		logic          err;
		apb_access(1'b1, {e[4:0], 3'b000}, word[31:0], rd, err);
		check_flag("pslverr", err, 1'b0);
		apb_access(1'b1, {e[4:0], 3'b100}, word[63:32], rd, err);
		check_flag("pslverr", err, 1'b0);
		tbl_model[e] = word;
	endtask

	task automatic read_entry_check(input int e);
		logic [WW-1:0] rd;
		logic          err;
		apb_access(1'b0, {e[4:0], 3'b000}, '0, rd, err);
		check_flag("pslverr", err, 1'b0);
		check_word("prdata low", rd, tbl_model[e][31:0]);
		apb_access(1'b0, {e[4:0], 3'b100}, '0, rd, err);
		check_flag("pslverr", err, 1'b0);
		check_word("prdata high", rd, tbl_model[e][63:32]);
	endtask

	function automatic depar_act_t make_act(input logic [6:0] offset, input logic [2:0] index,
		input cont_size_e size, input logic enable);
		depar_act_t a;
		a.spare = 3'b000;
		a.offset = offset;
		a.index = index;
		a.size = size;
		a.enable = enable;
		return a;
	endfunction

	function automatic logic [PW-1:0] make_phv(input logic [4:0] entry, input logic discard);
		logic [PW-1:0] p;
		for (int i = 0; i < PW / DW; i++) begin
			p[i*DW +: DW] = rand_data();
		end
		p[128] = discard;
		p[140:129] = {3'b101, entry, 4'h6};  // vlan bits 8:4 pick the entry
		return p;
	endfunction

	// containers go in msb first and later actions win
	// fields running past byte 63 are dropped
	function automatic logic [2*DW-1:0] patch_header(input logic [2*DW-1:0] hdr,
		input act_entry_t ent, input logic [PW-1:0] phv);
		logic [47:0] cont;
		int          nbytes;
		int          base;
		int          off;
		for (int i = 0; i < `DEPAR_NUM_ACT; i++) begin
			nbytes = 2 * int'(ent[i].size);
			off = int'(ent[i].offset);
			case (ent[i].size)
				B2: base = 256 + int'(ent[i].index) * 16;
				B4: base = 384 + int'(ent[i].index) * 32;
				default: base = 640 + int'(ent[i].index) * 48;
			endcase
			if (ent[i].enable && nbytes > 0 && off + nbytes <= 64) begin
				cont = phv[base +: 48];
				for (int k = 0; k < nbytes; k++) begin
					hdr[(off + k)*8 +: 8] = cont[(nbytes - 1 - k)*8 +: 8];
				end
			end
		end
		return hdr;
	endfunction

	task automatic send_packet(input int nbeats, input logic [PW-1:0] phv);
		beat_t           beats [8];
		logic [DW-1:0]   r;
		logic [2*DW-1:0] hdr;
		act_entry_t      ent;
		for (int i = 0; i < nbeats; i++) begin
			r = rand_data();
			beats[i].data = rand_data();
			beats[i].keep = (i == nbeats - 1) ? 32'h00ff_ffff : '1;
			beats[i].user = r[UW-1:0];
			beats[i].last = (i == nbeats - 1);
			in_q.push_back(beats[i]);
		end
		phv_q.push_back(phv);
		if (!phv[128]) begin
			ent = act_entry_t'(tbl_model[phv[137:133]]);
			hdr = {(nbeats > 1) ? beats[1].data : '0, beats[0].data};
			hdr = patch_header(hdr, ent, phv);
			beats[0].data = hdr[DW-1:0];
			beats[0].user = phv[127:0];
			if (nbeats > 1) begin
				beats[1].data = hdr[2*DW-1:DW];
			end
			for (int i = 0; i < nbeats; i++) begin
				exp_q.push_back(beats[i]);
			end
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		while (in_q.size() > 0 || phv_q.size() > 0 || got_q.size() < exp_q.size()) begin
			@(posedge clk);
			#1;
		end
		if (got_q.size() != exp_q.size()) begin
			$display("%s: %0d beats came out but %0d were expected", name, got_q.size(),
				exp_q.size());
			other_errors++;
		end
		n = 0;
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			check_beat(n, got_q.pop_front(), exp_q.pop_front());
			n++;
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic test_apb_access();
		logic [WW-1:0] rd;
		logic          err;
		write_entry(20, {lcg_next(), lcg_next()});
		write_entry(21, {lcg_next(), lcg_next()});
		write_entry(2, {lcg_next(), lcg_next()});
		read_entry_check(20);
		read_entry_check(21);
		read_entry_check(2);
		apb_access(1'b1, {5'd20, 3'b010}, 32'hdead_beef, rd, err);  // misaligned write
		check_flag("pslverr", err, 1'b1);
		apb_access(1'b0, {5'd21, 3'b110}, '0, rd, err);
		check_flag("pslverr", err, 1'b1);
		read_entry_check(20);
	endtask

	task automatic test_patching();
		act_entry_t ent;
		ent[0] = make_act(7'd12, 3'd5, B2, 1'b1);
		ent[1] = make_act(7'd30, 3'd2, B4, 1'b1);
		ent[2] = make_act(7'd33, 3'd7, B6, 1'b1);  // overlaps byte 33
		ent[3] = make_act(7'd50, 3'd1, B4, 1'b0);
		write_entry(4, ent);
		send_packet(2, make_phv(5'd4, 1'b0));
		finish_test("patching");
	endtask

	task automatic test_table_select();
		act_entry_t ent;
		ent[0] = make_act(7'd62, 3'd1, B6, 1'b1);  // runs past the buffer
		ent[1] = make_act(7'd2, 3'd6, B4, 1'b1);
		ent[2] = make_act(7'd0, 3'd0, NONE, 1'b0);
		ent[3] = make_act(7'd0, 3'd0, NONE, 1'b0);
		write_entry(7, ent);
		ent[0] = make_act(7'd5, 3'd3, B4, 1'b0);
		ent[1] = make_act(7'd40, 3'd4, B2, 1'b0);
		ent[2] = make_act(7'd20, 3'd2, B6, 1'b0);
		write_entry(9, ent);
		send_packet(2, make_phv(5'd7, 1'b0));
		send_packet(2, make_phv(5'd9, 1'b0));
		finish_test("table select");
	endtask

	task automatic test_back_pressure();
		act_entry_t ent;
		ent = '0;
		ent[0] = make_act(7'd0, 3'd0, B2, 1'b1);
		write_entry(11, ent);
		bp_mode = 1'b1;
		send_packet(5, make_phv(5'd11, 1'b0));
		finish_test("back pressure");
		bp_mode = 1'b0;
	endtask

	task automatic test_discard();
		send_packet(3, make_phv(5'd7, 1'b1));
		send_packet(2, make_phv(5'd4, 1'b0));
		finish_test("discard");
	endtask

	initial begin
		#(NUM_TESTS * 2000 * 8);
		$display("watchdog expired, the tests did not complete in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		for (int i = 0; i < `DEPAR_TBL_DEPTH; i++) begin
			tbl_model[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		aresetn = 1'b1;
		@(posedge clk);
		#1;
		test_apb_access();
		test_patching();
		test_table_select();
		test_back_pressure();
		test_discard();
		$display("done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
